// File: Makefile
# Verilator simulation of the denise pixel path

VERILATOR ?= verilator
TOP       ?= denise_tb
FILELIST  ?= denise_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: denise_top.f
hw/denise_pkg.sv
hw/register_bank.sv
hw/display_window.sv
hw/colour_palette.sv
hw/ham_decoder.sv
hw/video_output.sv
hw/denise_top.sv
verification/denise_checker.sv
verification/denise_tb.sv

// File: hw/colour_palette.sv
`default_nettype none

module colour_palette
(
	input  wire logic                  clk,
	input  wire denise_pkg::reg_addr_t reg_address,
	input  wire denise_pkg::bus_data_t data,
	input  wire logic                  ehb_off,	// disables extra half brite
	input  wire denise_pkg::pixel_t    pixel,
	output denise_pkg::rgb_t           clut_rgb,	// registered palette colour
	output denise_pkg::rgb_t           base_rgb,	// unregistered read for the ham decoder
	output denise_pkg::pixel_t         pixel_d	// pixel, one cycle later
);

	denise_pkg::rgb_t palette [denise_pkg::palette_entries];	// colour registers

	denise_pkg::reg_addr_t entry_offset;		// address relative to colour00
	denise_pkg::colour_sel_t select;
	denise_pkg::rgb_t sel_colour;
	logic wr_colour;

	// --------------------
	// bus writes

	assign entry_offset = reg_address - denise_pkg::addr_colour_base;
	assign wr_colour = (reg_address >= denise_pkg::addr_colour_base) &&
			(reg_address <= denise_pkg::addr_colour_last);

	always_ff @(posedge clk)
	begin
		if (wr_colour)
			palette[entry_offset[4:0]] <= data[11:0];
	end

	// --------------------
	// lookup

	assign select     = pixel.window ? pixel.planes : '0;	// border is colour00
	assign sel_colour = palette[select[4:0]];
	assign base_rgb   = palette[{1'b0, pixel.planes[3:0]}];	// ham only sees 0 to 15

	always_ff @(posedge clk)
	begin
		if (select[5] && !ehb_off)
			clut_rgb <= {1'b0, sel_colour[11:9], 1'b0, sel_colour[7:5], 1'b0, sel_colour[3:1]};
		else
			clut_rgb <= sel_colour;
		pixel_d <= pixel;			// keep window and blank in step with the colour
	end

endmodule

`default_nettype wire

// File: hw/denise_pkg.sv
`default_nettype none

package denise_pkg;

	// --------------------
	// vector types

	typedef logic [7:0]  reg_addr_t;		// register word address, bus address bits 8:1
	typedef logic [15:0] bus_data_t;		// bus write data
	typedef logic [11:0] rgb_t;			// 4 bits per gun, red on top
	typedef logic [8:0]  hpos_t;			// horizontal beam position
	typedef logic [5:0]  colour_sel_t;		// bit 5 is ehb, bits 4:0 pick the entry
	typedef logic [5:0]  plane_bits_t;		// one pixel of serial bitplane data
	typedef logic [3:0]  bpu_t;			// number of enabled bitplanes

	// hold and modify opcode, lives in plane bits 5:4
	typedef enum logic [1:0] {
		ham_load  = 2'd0,			// take colour from the palette
		ham_blue  = 2'd1,			// modify blue only
		ham_red   = 2'd2,			// modify red only
		ham_green = 2'd3			// modify green only
	} ham_op_t;

	typedef struct packed {
		plane_bits_t planes;			// after the plane count mask
		logic        window;			// inside the display window
		logic        blank;			// beam is in blanking
	} pixel_t;

	typedef struct packed {
		logic hires;				// bplcon0 bit 15
		logic homod;				// bplcon0 bit 11
		bpu_t bpu;				// plane count latched by bpl1dat
	} ctrl_t;

	// --------------------
	// register word addresses

	localparam reg_addr_t addr_diwstrt     = 8'h47;
	localparam reg_addr_t addr_diwstop     = 8'h48;
	localparam reg_addr_t addr_diwhigh     = 8'hF2;
	localparam reg_addr_t addr_bplcon0     = 8'h80;
	localparam reg_addr_t addr_bpl1dat     = 8'h88;
	localparam reg_addr_t addr_colour_base = 8'hC0;

	localparam int palette_entries = 32;
	localparam reg_addr_t addr_colour_last = reg_addr_t'(addr_colour_base + palette_entries - 1);

	localparam hpos_t hpos_restart = 9'd2;		// counter value after strhor

endpackage

`default_nettype wire

// File: hw/denise_top.sv
`default_nettype none

module denise_top
(
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire logic                    strhor,		// horizontal strobe
	input  wire denise_pkg::reg_addr_t   reg_address,
	input  wire denise_pkg::bus_data_t   data,
	input  wire denise_pkg::plane_bits_t planes,		// serial bitplane bits
	input  wire logic                    blank,
	input  wire logic                    ecs,
	input  wire logic                    ehb_off,
	output denise_pkg::rgb_t             rgb,
	output logic                         hires		// for the scandoubler
);

	denise_pkg::ctrl_t       ctrl;
	denise_pkg::hpos_t       hdiwstrt;
	denise_pkg::hpos_t       hdiwstop;
	logic                    window_ena;
	denise_pkg::plane_bits_t planes_m;		// planes after the count mask
	denise_pkg::pixel_t      pixel;
	denise_pkg::pixel_t      pixel_d;
	denise_pkg::rgb_t        clut_rgb;
	denise_pkg::rgb_t        base_rgb;
	denise_pkg::rgb_t        ham_rgb;

	assign hires = ctrl.hires;

	// --------------------
	// input side

	register_bank u_regs (.clk, .reset, .reg_address, .data, .ecs, .ctrl, .hdiwstrt, .hdiwstop);

	display_window u_window (.clk, .reset, .strhor, .hdiwstrt, .hdiwstop, .window_ena);

	// plane n passes only when bpu is at least n
	always_comb
	begin
		for (int n = 0; n < 6; n++)
			planes_m[n] = planes[n] && (ctrl.bpu > 4'(n));
	end

	assign pixel = '{planes: planes_m, window: window_ena, blank: blank};

	// --------------------
	// colour and output

	colour_palette u_palette (.clk, .reg_address, .data, .ehb_off, .pixel,
			.clut_rgb, .base_rgb, .pixel_d);

	ham_decoder u_ham (.clk, .planes(pixel.planes), .base_rgb, .ham_rgb);

	video_output u_out (.clk, .reset, .homod(ctrl.homod), .pixel_d, .clut_rgb, .ham_rgb, .rgb);

endmodule

`default_nettype wire

// File: hw/display_window.sv
`default_nettype none

module display_window
(
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire logic              strhor,		// start of line strobe
	input  wire denise_pkg::hpos_t hdiwstrt,
	input  wire denise_pkg::hpos_t hdiwstop,
	output logic                   window_ena	// window aligned with the pixel input
);

	denise_pkg::hpos_t hpos;			// local beam counter
	logic window;					// raw window level

	// beam counter, resynced on every line
	always_ff @(posedge clk)
	begin
		if (reset)
			hpos <= '0;
		else if (strhor)
			hpos <= denise_pkg::hpos_restart;
		else
			hpos <= hpos + 9'd1;
	end

	// window set at start, cleared at stop, then delayed one cycle
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			window     <= 1'b0;
			window_ena <= 1'b0;
		end
		else
		begin
			if (hpos == hdiwstrt)
				window <= 1'b1;
			else if (hpos == hdiwstop)
				window <= 1'b0;
			window_ena <= window;
		end
	end

endmodule

`default_nettype wire

// File: hw/ham_decoder.sv
`default_nettype none

module ham_decoder
(
	input  wire logic                    clk,
	input  wire denise_pkg::plane_bits_t planes,	// masked plane bits
	input  wire denise_pkg::rgb_t        base_rgb,	// palette entry picked by planes 3:0
	output denise_pkg::rgb_t             ham_rgb	// held colour
);

	denise_pkg::ham_op_t op;
	logic [3:0] value;				// new value for the modified gun

	assign op    = denise_pkg::ham_op_t'(planes[5:4]);
	assign value = planes[3:0];

	// hold and modify, runs on every pixel
	always_ff @(posedge clk)
	begin
		case (op)
			denise_pkg::ham_load:
				ham_rgb <= base_rgb;
			denise_pkg::ham_blue:
				ham_rgb <= {ham_rgb[11:4], value};	// keep red and green
			denise_pkg::ham_red:
				ham_rgb <= {value, ham_rgb[7:0]};	// keep green and blue
			denise_pkg::ham_green:
				ham_rgb <= {ham_rgb[11:8], value, ham_rgb[3:0]};
			default:
				ham_rgb <= ham_rgb;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/register_bank.sv
`default_nettype none

module register_bank
(
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire denise_pkg::reg_addr_t reg_address,
	input  wire denise_pkg::bus_data_t data,
	input  wire logic                  ecs,		// ecs features enabled
	output denise_pkg::ctrl_t          ctrl,
	output denise_pkg::hpos_t          hdiwstrt,	// window start, 9 bits
	output denise_pkg::hpos_t          hdiwstop	// window stop, 9 bits
);

	denise_pkg::bpu_t bpu_pending;			// count from bplcon0, not yet in use

	logic wr_bplcon0;
	logic wr_bpl1dat;
	logic wr_diwstrt;
	logic wr_diwstop;
	logic wr_diwhigh;

	// address decode, one strobe per register
	assign wr_bplcon0 = (reg_address == denise_pkg::addr_bplcon0);
	assign wr_bpl1dat = (reg_address == denise_pkg::addr_bpl1dat);
	assign wr_diwstrt = (reg_address == denise_pkg::addr_diwstrt);
	assign wr_diwstop = (reg_address == denise_pkg::addr_diwstop);
	assign wr_diwhigh = (reg_address == denise_pkg::addr_diwhigh) && ecs;	// ocs ignores diwhigh

	// --------------------
	// bplcon0 and the latched plane count

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ctrl        <= '0;
			bpu_pending <= '0;
		end
		else
		begin
			if (wr_bplcon0)
			begin
				ctrl.hires  <= data[15];
				ctrl.homod  <= data[11];
				bpu_pending <= {data[4], data[14:12]};	// bit 4 is the ecs high bit
			end
			if (wr_bpl1dat)
				ctrl.bpu <= bpu_pending;	// planes switch on at the first data word
		end
	end

	// --------------------
	// horizontal window limits

	always_ff @(posedge clk)
	begin
		if (wr_diwstrt)
			hdiwstrt <= {1'b0, data[7:0]};	// start always in the low half
		else if (wr_diwhigh)
			hdiwstrt[8] <= data[5];

		if (wr_diwstop)
			hdiwstop <= {1'b1, data[7:0]};	// stop always in the high half
		else if (wr_diwhigh)
			hdiwstop[8] <= data[13];
	end

endmodule

`default_nettype wire

// File: hw/video_output.sv
`default_nettype none

module video_output
(
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire logic               homod,		// ham mode on
	input  wire denise_pkg::pixel_t pixel_d,
	input  wire denise_pkg::rgb_t   clut_rgb,
	input  wire denise_pkg::rgb_t   ham_rgb,
	output denise_pkg::rgb_t        rgb		// final video out
);

	denise_pkg::rgb_t out_rgb;			// colour before the output register

	// ham only inside the window, border stays a palette colour
	always_comb
	begin
		if (pixel_d.blank)
			out_rgb = '0;
		else if (homod && pixel_d.window)
			out_rgb = ham_rgb;
		else
			out_rgb = clut_rgb;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			rgb <= '0;
		else
			rgb <= out_rgb;
	end

endmodule

`default_nettype wire

// File: verification/denise_checker.sv
`default_nettype none

module denise_checker
(
	input wire logic             clk,
	input wire logic             reset,
	input wire logic             blank,
	input wire logic             hires,
	input wire denise_pkg::rgb_t rgb
);
	timeunit 1ns;
	timeprecision 100ps;

	// --------------------
	// outputs leave reset at zero
	reset_values: assert property (@(posedge clk) reset |=> (rgb == '0 && hires == 1'b0))
		else $error("rgb or hires not zero after reset");

	// blank reaches the output register two cycles later
	blank_output: assert property (@(posedge clk) disable iff (reset) blank |=> ##1 (rgb == '0))
		else $error("rgb not zero two cycles after blank");

endmodule

bind denise_top denise_checker i_checker (.clk, .reset, .blank, .hires, .rgb);

`default_nettype wire

// File: verification/denise_tb.sv
`default_nettype none

module denise_tb;
	timeunit 1ns;
	timeprecision 100ps;

	typedef enum logic [1:0] {row_write, row_pixels, row_strhor} row_kind_t;
	typedef struct packed {
		row_kind_t kind;
		logic [2:0] test;			// behavior number
		denise_pkg::reg_addr_t addr;
		denise_pkg::bus_data_t data;
		logic [1:0] mode;			// planes: 0 zero, 1 ramp, 2 lfsr
		logic [9:0] count;			// pixels in a run
		logic blank, ecs, ehb_off, chk_rgb, chk_hires, exp_hires;
	} row_t;

	logic clk = 0, reset = 1, strhor = 0, blank = 0, ecs = 0, ehb_off = 0;
	denise_pkg::reg_addr_t reg_address = 8'hFF;	// 0xff is not decoded
	denise_pkg::bus_data_t data = '0;
	denise_pkg::plane_bits_t planes = '0;
	denise_pkg::rgb_t rgb;
	logic hires;

	row_t rows[$];
	row_t idle_row;
	string test_name[1:6] = '{"reset and hires", "palette and ehb", "display window",
		"plane mask", "ham mode", "blank"};
	int errors = 0, test_errors = 0, checks = 0, cycles = 0, cycle_limit = 0;
	logic [15:0] lfsr = 16'd4408;

	// reference model state
	denise_pkg::hpos_t m_hpos, m_strt, m_stop;
	logic m_window, m_win_ena, m_pd_win, m_pd_blank, m_homod;
	denise_pkg::bpu_t m_bpu, m_bpu_pend;
	denise_pkg::rgb_t m_pal [32];
	denise_pkg::rgb_t m_clut, m_ham, m_rgb;
	// inputs held during the current cycle, plus check flags down the pipe
	denise_pkg::reg_addr_t cur_addr = 8'hFF;
	denise_pkg::bus_data_t cur_data = '0;
	denise_pkg::plane_bits_t cur_planes = '0;
	logic cur_strhor = 0, cur_blank = 0, cur_ecs = 0, cur_ehb = 0;
	logic cur_chk = 0, cur_chk_h = 0, cur_exp_h = 0;
	logic chk_d1 = 0, chk_rgb_now = 0, chk_h_now = 0, exp_h_now = 0;

	denise_top i_dut (.clk, .reset, .strhor, .reg_address, .data, .planes, .blank, .ecs,
		.ehb_off, .rgb, .hires);

	initial forever #2 clk = ~clk;			// 4 ns period

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};	// x^16+x^14+x^13+x^11
	endfunction

	function automatic denise_pkg::rgb_t halve(input denise_pkg::rgb_t c);
		logic [3:0] r, g, b;
		r = c[11:8] >> 1;
		g = c[7:4] >> 1;
		b = c[3:0] >> 1;
		return {r, g, b};
	endfunction

	task automatic check_rgb(input denise_pkg::rgb_t act, input denise_pkg::rgb_t exp,
		input string name);
		checks++;
		if (act !== exp)
		begin
			errors++;
			test_errors++;
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, act, exp);
		end
	endtask

	task automatic check_hires(input logic act, input logic exp, input string name);
		checks++;
		if (act !== exp)
		begin
			errors++;
			test_errors++;
			$display("Fail at %0t ns: %s is %b, expected %b", $time, name, act, exp);
		end
	endtask

	task automatic add_row(input row_kind_t k, input int t, input denise_pkg::reg_addr_t a,
		input denise_pkg::bus_data_t d, input int mode, input int cnt, input logic bl,
		input logic ec, input logic eo, input logic cr, input logic ch, input logic eh);
		rows.push_back(row_t'{k, 3'(t), a, d, 2'(mode), 10'(cnt), bl, ec, eo, cr, ch, eh});
	endtask

	// --------------------
	// one register update of the modelled pipeline, from the rules
	task automatic model_step();
		denise_pkg::plane_bits_t mp;
		denise_pkg::colour_sel_t sel;
		denise_pkg::rgb_t n_clut, n_ham, n_rgb, base;
		logic n_win;
		for (int n = 0; n < 6; n++)
			mp[n] = cur_planes[n] && (m_bpu >= 4'(n + 1));	// plane n+1 needs bpu > n
		sel = m_win_ena ? mp : '0;		// border uses colour 0
		n_clut = (sel[5] && !cur_ehb) ? halve(m_pal[sel[4:0]]) : m_pal[sel[4:0]];
		base = m_pal[{1'b0, mp[3:0]}];
		case (denise_pkg::ham_op_t'(mp[5:4]))
			denise_pkg::ham_load:  n_ham = base;
			denise_pkg::ham_blue:  n_ham = {m_ham[11:4], mp[3:0]};
			denise_pkg::ham_red:   n_ham = {mp[3:0], m_ham[7:0]};
			default:               n_ham = {m_ham[11:8], mp[3:0], m_ham[3:0]};
		endcase
		n_rgb = m_pd_blank ? '0 : ((m_homod && m_pd_win) ? m_ham : m_clut);
		n_win = (m_hpos == m_strt) ? 1'b1 : ((m_hpos == m_stop) ? 1'b0 : m_window);
		m_rgb = n_rgb;
		m_clut = n_clut;
		m_ham = n_ham;
		m_pd_win = m_win_ena;
		m_pd_blank = cur_blank;
		m_win_ena = m_window;
		m_window = n_win;
		m_hpos = cur_strhor ? denise_pkg::hpos_restart : m_hpos + 9'd1;
		// register writes take effect for the next cycle
		if (cur_addr == denise_pkg::addr_bplcon0)
		begin
			m_homod = cur_data[11];
			m_bpu_pend = {cur_data[4], cur_data[14:12]};
		end
		if (cur_addr == denise_pkg::addr_bpl1dat)
			m_bpu = m_bpu_pend;
		if (cur_addr == denise_pkg::addr_diwstrt)
			m_strt = {1'b0, cur_data[7:0]};
		if (cur_addr == denise_pkg::addr_diwstop)
			m_stop = {1'b1, cur_data[7:0]};
		if (cur_addr == denise_pkg::addr_diwhigh && cur_ecs)
		begin
			m_strt[8] = cur_data[5];
			m_stop[8] = cur_data[13];
		end
		if (cur_addr >= 8'hC0 && cur_addr <= 8'hDF)
			m_pal[5'(cur_addr - denise_pkg::addr_colour_base)] = cur_data[11:0];
		chk_rgb_now = chk_d1;			// pixel from two cycles back
		chk_d1 = cur_chk;
		chk_h_now = cur_chk_h;
		exp_h_now = cur_exp_h;
	endtask

	// clock edge, model update, new inputs, then checks at the falling edge
	task automatic run_cycle(input row_t r, input int i);
		denise_pkg::plane_bits_t pl;
		@(posedge clk);
		model_step();
		pl = '0;
		if (r.kind == row_pixels && r.mode == 2'd1)
			pl = 6'(i);
		else if (r.kind == row_pixels && r.mode == 2'd2)
			for (int b = 0; b < 6; b++)
			begin
				pl[b] = lfsr[15];		// one lfsr step per bit
				lfsr = lfsr_step(lfsr);
			end
		cur_addr = (r.kind == row_write) ? r.addr : 8'hFF;
		cur_data = r.data;
		cur_strhor = (r.kind == row_strhor);
		cur_planes = pl;
		cur_blank = r.blank && (r.kind == row_pixels);
		cur_ecs = r.ecs;
		cur_ehb = r.ehb_off;
		cur_chk = r.chk_rgb && (r.kind == row_pixels);
		cur_chk_h = r.chk_hires;
		cur_exp_h = r.exp_hires;
		reg_address <= cur_addr;
		data <= cur_data;
		strhor <= cur_strhor;
		planes <= cur_planes;
		blank <= cur_blank;
		ecs <= cur_ecs;
		ehb_off <= cur_ehb;
		@(negedge clk);
		if (chk_rgb_now)
			check_rgb(rgb, m_rgb, "rgb");
		if (chk_h_now)
			check_hires(hires, exp_h_now, "hires");
	endtask

	task automatic finish_test(input int t);
		run_cycle(idle_row, 0);			// drain the two pipeline stages
		run_cycle(idle_row, 0);
		$display("test %0d %s: %s (%0d errors)", t, test_name[t],
			(test_errors == 0) ? "ok" : "FAIL", test_errors);
	endtask

	// --------------------
	// watchdog
	initial
	begin
		wait (cycle_limit != 0);
		while (cycles < cycle_limit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", cycle_limit);
		$display("Testbench failed");
		$finish;
	end

	initial
	begin
		int cur_test, n, total;
		idle_row = '{row_write, 3'd0, 8'hFF, 16'h0, 2'd0, 10'd1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
		// 1: limits 16 to 0x150, palette, hires, six planes, then a line to settle the window
		add_row(row_write, 1, 8'h47, 16'h0010, 0, 1, 0, 0, 0, 0, 1, 0);
		add_row(row_write, 1, 8'h48, 16'h0050, 0, 1, 0, 0, 0, 0, 1, 0);
		for (int e = 0; e < 32; e++)
			add_row(row_write, 1, 8'(8'hC0 + e), 16'((e * 16'h139 + 16'h0A5) & 16'hFFF),
				0, 1, 0, 0, 0, 0, 0, 0);
		add_row(row_write, 1, 8'h80, 16'h8000, 0, 1, 0, 0, 0, 0, 1, 1);
		add_row(row_write, 1, 8'h80, 16'h6000, 0, 1, 0, 0, 0, 0, 1, 0);
		add_row(row_write, 1, 8'h88, 16'h0000, 0, 1, 0, 0, 0, 0, 0, 0);
		add_row(row_strhor, 1, 8'hFF, 16'h0, 0, 1, 0, 0, 0, 0, 0, 0);
		add_row(row_pixels, 1, 8'hFF, 16'h0, 0, 340, 0, 0, 0, 0, 0, 0);
		// 2: every select, ehb on and off, count pending but not latched
		add_row(row_strhor, 2, 8'hFF, 16'h0, 0, 1, 0, 0, 0, 0, 0, 0);
		add_row(row_pixels, 2, 8'hFF, 16'h0, 0, 20, 0, 0, 0, 1, 0, 0);
		add_row(row_pixels, 2, 8'hFF, 16'h0, 1, 64, 0, 0, 0, 1, 0, 0);
		add_row(row_pixels, 2, 8'hFF, 16'h0, 1, 64, 0, 0, 1, 1, 0, 0);
		add_row(row_write, 2, 8'h80, 16'h2000, 0, 1, 0, 0, 0, 0, 1, 0);
		add_row(row_pixels, 2, 8'hFF, 16'h0, 1, 64, 0, 0, 0, 1, 0, 0);
		// 3: window edges, diwhigh ignored in ocs, start moved to 0x110 in ecs
		add_row(row_strhor, 3, 8'hFF, 16'h0, 0, 1, 0, 0, 0, 0, 0, 0);
		add_row(row_pixels, 3, 8'hFF, 16'h0, 2, 345, 0, 0, 0, 1, 0, 0);
		add_row(row_write, 3, 8'hF2, 16'h0020, 0, 1, 0, 0, 0, 0, 0, 0);
		add_row(row_strhor, 3, 8'hFF, 16'h0, 0, 1, 0, 0, 0, 0, 0, 0);
		add_row(row_pixels, 3, 8'hFF, 16'h0, 2, 345, 0, 0, 0, 1, 0, 0);
		add_row(row_write, 3, 8'hF2, 16'h2020, 0, 1, 0, 1, 0, 0, 0, 0);
		add_row(row_strhor, 3, 8'hFF, 16'h0, 0, 1, 0, 0, 0, 0, 0, 0);
		add_row(row_pixels, 3, 8'hFF, 16'h0, 2, 345, 0, 0, 0, 1, 0, 0);
		add_row(row_write, 3, 8'h47, 16'h0010, 0, 1, 0, 0, 0, 0, 0, 0);
		// 4: latch two planes, ramp through the mask
		add_row(row_write, 4, 8'h88, 16'h0000, 0, 1, 0, 0, 0, 0, 0, 0);
		add_row(row_strhor, 4, 8'hFF, 16'h0, 0, 1, 0, 0, 0, 0, 0, 0);
		add_row(row_pixels, 4, 8'hFF, 16'h0, 0, 20, 0, 0, 0, 1, 0, 0);
		add_row(row_pixels, 4, 8'hFF, 16'h0, 1, 64, 0, 0, 0, 1, 0, 0);
		// 5: ham with six planes, lead in with loads of colour 0
		add_row(row_write, 5, 8'h80, 16'h6800, 0, 1, 0, 0, 0, 0, 1, 0);
		add_row(row_write, 5, 8'h88, 16'h0000, 0, 1, 0, 0, 0, 0, 0, 0);
		add_row(row_strhor, 5, 8'hFF, 16'h0, 0, 1, 0, 0, 0, 0, 0, 0);
		add_row(row_pixels, 5, 8'hFF, 16'h0, 0, 4, 0, 0, 0, 1, 0, 0);
		add_row(row_pixels, 5, 8'hFF, 16'h0, 2, 100, 0, 0, 0, 1, 0, 0);
		// 6: blank in ham and palette mode
		add_row(row_pixels, 6, 8'hFF, 16'h0, 2, 30, 1, 0, 0, 1, 0, 0);
		add_row(row_write, 6, 8'h80, 16'h6000, 0, 1, 0, 0, 0, 0, 1, 0);
		add_row(row_pixels, 6, 8'hFF, 16'h0, 2, 30, 1, 0, 0, 1, 0, 0);
		add_row(row_pixels, 6, 8'hFF, 16'h0, 2, 20, 0, 0, 0, 1, 0, 0);
		total = 0;
		foreach (rows[r])
			total += (rows[r].kind == row_pixels) ? int'(rows[r].count) : 1;
		cycle_limit = 16 + total + 2 * 6 + 200;	// reset, rows, drains, margin

		repeat (16) @(posedge clk);
		reset <= 1'b0;
		// model now holds the reset state
		m_hpos = '0;
		m_window = 0;
		m_win_ena = 0;
		m_pd_win = 0;
		m_pd_blank = 0;
		m_homod = 0;
		m_bpu = '0;
		m_bpu_pend = '0;
		m_rgb = '0;
		@(negedge clk);
		check_rgb(rgb, '0, "rgb");
		check_hires(hires, 1'b0, "hires");

		cur_test = 1;
		for (int r = 0; r < rows.size(); r++)
		begin
			if (int'(rows[r].test) != cur_test)
			begin
				finish_test(cur_test);
				cur_test = rows[r].test;
				test_errors = 0;
			end
			n = (rows[r].kind == row_pixels) ? int'(rows[r].count) : 1;
			for (int i = 0; i < n; i++)
				run_cycle(rows[r], i);
		end
		finish_test(cur_test);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire
